// File: gate_array_video.f
source/video_timing_pkg.sv
source/z80_bus_pkg.sv
source/crtc_timing.sv
source/sync_int_gen.sv
source/ga_cmd_decode.sv
source/gate_array_video.sv
verif/tb_gate_array_video.sv

// File: source/crtc_timing.sv
// free running from reset; needs HSYNC_START > 0 and hsync and vsync inside their line and frame
`timescale 1ns/1ns

module crtc_timing #(
	parameter int CLK_DIV     = video_timing_pkg::DEF_CLK_DIV,
	parameter int H_TOTAL     = video_timing_pkg::DEF_H_TOTAL,
	parameter int HSYNC_START = video_timing_pkg::DEF_HSYNC_START,
	parameter int HSYNC_WIDTH = video_timing_pkg::DEF_HSYNC_WIDTH,
	parameter int V_TOTAL     = video_timing_pkg::DEF_V_TOTAL,
	parameter int VSYNC_START = video_timing_pkg::DEF_VSYNC_START,
	parameter int VSYNC_WIDTH = video_timing_pkg::DEF_VSYNC_WIDTH
) (
	input  logic clk,
	input  logic int_reset,
	output logic cclk_en,   // 1 clk every CLK_DIV
	output logic hsync_raw,
	output logic vsync_raw
);

	localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
	localparam int H_W   = $clog2(H_TOTAL);
	localparam int V_W   = $clog2(V_TOTAL);

	logic [DIV_W-1:0] div_cnt;
	logic [H_W-1:0]   h_cnt;     // char within line
	logic [H_W-1:0]   h_next;
	logic [V_W-1:0]   v_cnt;     // line within frame
	logic [V_W-1:0]   v_next;
	logic             line_end;  // last char of the line
	video_timing_pkg::hphase_e hphase;
	video_timing_pkg::hphase_e hphase_next;

	// ============================================================
	// char clock divider
	// ============================================================

	assign cclk_en = (div_cnt == DIV_W'(CLK_DIV - 1));

	always_ff @(posedge clk) begin
		if (int_reset) begin
			div_cnt <= '0;
		end else if (cclk_en) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// ============================================================
	// horizontal, char counter and phase
	// ============================================================

	assign line_end = (h_cnt == H_W'(H_TOTAL - 1));
	assign h_next   = line_end ? '0 : h_cnt + 1'b1;
	assign v_next   = (v_cnt == V_W'(V_TOTAL - 1)) ? '0 : v_cnt + 1'b1;

	// phase looks at the char being entered
	always_comb begin
		hphase_next = hphase;
		case (hphase)
			video_timing_pkg::HP_DISPLAY: begin
				if (32'(h_next) == HSYNC_START) begin
					hphase_next = video_timing_pkg::HP_SYNC;
				end
			end
			video_timing_pkg::HP_SYNC: begin
				if (h_next == '0) begin
					hphase_next = video_timing_pkg::HP_DISPLAY; // sync ran to line end
				end else if (32'(h_next) == HSYNC_START + HSYNC_WIDTH) begin
					hphase_next = video_timing_pkg::HP_PORCH;
				end
			end
			video_timing_pkg::HP_PORCH: begin
				if (h_next == '0) begin
					hphase_next = video_timing_pkg::HP_DISPLAY;
				end
			end
			default: hphase_next = video_timing_pkg::HP_DISPLAY;
		endcase
	end

	assign hsync_raw = (hphase == video_timing_pkg::HP_SYNC);

	// ============================================================
	// counters, all stepped on char clock
	// ============================================================

	always_ff @(posedge clk) begin
		if (int_reset) begin
			h_cnt     <= '0;
			v_cnt     <= '0;
			hphase    <= video_timing_pkg::HP_DISPLAY;
			vsync_raw <= 1'b0;
		end else if (cclk_en) begin
			h_cnt  <= h_next;
			hphase <= hphase_next;
			if (line_end) begin
				v_cnt     <= v_next;
				// vsync window in whole lines
				vsync_raw <= (32'(v_next) >= VSYNC_START) &&
				             (32'(v_next) < VSYNC_START + VSYNC_WIDTH);
			end
		end
	end

endmodule

// File: source/ga_cmd_decode.sv
// decodes writes with a15 low only; pen, colour and RAM writes are taken and ignored here
`timescale 1ns/1ns

module ga_cmd_decode (
	input  logic clk,
	input  logic int_reset,
	input  logic a15,          // gate array selected when low
	input  logic iorq_n,
	input  logic wr_n,
	input  logic m1_n,
	input  logic [7:0] io_data,
	input  logic mode_sync_en, // hsync end from sync_int_gen
	output logic irq_clear,
	output video_timing_pkg::screen_mode_e video_mode
);

	logic iorq_n_d;
	logic wr_edge;             // one clk per io write
	z80_bus_pkg::ga_func_e ga_func;
	video_timing_pkg::screen_mode_e mode_pend;

	// ============================================================
	// write strobe
	// ============================================================

	// iorq fall, m1 high rules out int ack
	assign wr_edge = iorq_n_d & ~iorq_n & ~wr_n & m1_n & ~a15;
	assign ga_func = z80_bus_pkg::ga_func_e'(io_data[7:6]);

	always_ff @(posedge clk) begin
		if (int_reset) begin
			iorq_n_d <= 1'b1;
		end else begin
			iorq_n_d <= iorq_n;
		end
	end

	// ============================================================
	// register decode
	// ============================================================

	always_ff @(posedge clk) begin
		if (int_reset) begin
			irq_clear <= 1'b0;
			mode_pend <= video_timing_pkg::MODE_1;
		end else begin
			irq_clear <= 1'b0; // pulse
			if (wr_edge) begin
				case (ga_func)
					z80_bus_pkg::FUNC_MODE_ROM: begin
						irq_clear <= io_data[z80_bus_pkg::RMR_INT_CLR_BIT];
						mode_pend <= video_timing_pkg::screen_mode_e'(
							io_data[z80_bus_pkg::RMR_MODE_LSB +: 2]);
					end
					z80_bus_pkg::FUNC_PEN_SEL,
					z80_bus_pkg::FUNC_COLOUR,
					z80_bus_pkg::FUNC_RAM_CFG: begin
						irq_clear <= 1'b0; // palette and banking live elsewhere
					end
					default: irq_clear <= 1'b0;
				endcase
			end
		end
	end

	// mode only switches at hsync end, no mid-line tearing
	always_ff @(posedge clk) begin
		if (int_reset) begin
			video_mode <= video_timing_pkg::MODE_1;
		end else if (mode_sync_en) begin
			video_mode <= mode_pend;
		end
	end

endmodule

// File: source/gate_array_video.sv
// sync timing runs from reset without CPU setup; only the seven raster values are tunable
`timescale 1ns/1ns

module gate_array_video #(
	parameter int CLK_DIV     = video_timing_pkg::DEF_CLK_DIV,
	parameter int H_TOTAL     = video_timing_pkg::DEF_H_TOTAL,
	parameter int HSYNC_START = video_timing_pkg::DEF_HSYNC_START,
	parameter int HSYNC_WIDTH = video_timing_pkg::DEF_HSYNC_WIDTH,
	parameter int V_TOTAL     = video_timing_pkg::DEF_V_TOTAL,
	parameter int VSYNC_START = video_timing_pkg::DEF_VSYNC_START,
	parameter int VSYNC_WIDTH = video_timing_pkg::DEF_VSYNC_WIDTH
) (
	input  logic clk,
	input  logic int_reset,
	input  logic a15,
	input  logic iorq_n,
	input  logic wr_n,
	input  logic m1_n,
	input  logic [7:0] io_data,
	output logic hsync_out,
	output logic vsync_out,
	output logic csync_n,
	output logic int_n,
	output video_timing_pkg::screen_mode_e video_mode
);

	logic cclk_en;
	logic hsync_raw;
	logic vsync_raw;
	logic mode_sync_en; // sync stage -> cmd stage
	logic irq_clear;    // cmd stage -> sync stage

	// ============================================================
	// raw raster timing
	// ============================================================

	crtc_timing #(
		.CLK_DIV     (CLK_DIV),
		.H_TOTAL     (H_TOTAL),
		.HSYNC_START (HSYNC_START),
		.HSYNC_WIDTH (HSYNC_WIDTH),
		.V_TOTAL     (V_TOTAL),
		.VSYNC_START (VSYNC_START),
		.VSYNC_WIDTH (VSYNC_WIDTH)
	) u_crtc_timing (
		.clk       (clk),
		.int_reset (int_reset),
		.cclk_en   (cclk_en),
		.hsync_raw (hsync_raw),
		.vsync_raw (vsync_raw)
	);

	sync_int_gen u_sync_int_gen (
		.clk          (clk),
		.int_reset    (int_reset),
		.cclk_en      (cclk_en),
		.hsync_raw    (hsync_raw),
		.vsync_raw    (vsync_raw),
		.irq_clear    (irq_clear),
		.iorq_n       (iorq_n),
		.m1_n         (m1_n),
		.hsync_out    (hsync_out),
		.vsync_out    (vsync_out),
		.csync_n      (csync_n),
		.int_n        (int_n),
		.mode_sync_en (mode_sync_en)
	);

	ga_cmd_decode u_ga_cmd_decode (
		.clk          (clk),
		.int_reset    (int_reset),
		.a15          (a15),
		.iorq_n       (iorq_n),
		.wr_n         (wr_n),
		.m1_n         (m1_n),
		.io_data      (io_data),
		.mode_sync_en (mode_sync_en),
		.irq_clear    (irq_clear),
		.video_mode   (video_mode)
	);

endmodule

// File: source/sync_int_gen.sv
// raw syncs must change only on cclk_en clocks; vsync_out stays off until the first raw vsync
`timescale 1ns/1ns

module sync_int_gen (
	input  logic clk,
	input  logic int_reset,
	input  logic cclk_en,
	input  logic hsync_raw,
	input  logic vsync_raw,
	input  logic irq_clear,    // from register write
	input  logic iorq_n,
	input  logic m1_n,
	output logic hsync_out,
	output logic vsync_out,
	output logic csync_n,
	output logic int_n,
	output logic mode_sync_en  // end of hsync_out
);

	localparam logic [4:0] VLINE_PARK = 5'h1E; // terminal count, vsync off

	logic       hsync_raw_d;
	logic       vsync_raw_d;
	logic       hcnt_cnt;     // line event, raw hsync fall
	logic       vs_raw_rise;
	logic [3:0] hdelay;       // gray-like hsync delay
	logic       hsync_out_d;
	logic [4:0] vline_cnt;
	logic [4:0] vline_next;
	logic       vsync_out_d;
	logic       vs_out_rise;
	logic [5:0] intcnt;       // lines since last int
	logic [5:0] intcnt_nxt;
	logic       clr52;        // folded latch, hit 52 until hsync
	logic       irqack;       // folded latch, ack until m1_n high
	logic       irq_clr_any;
	logic       intcnt_res0;  // clears bits 4:0
	logic       intcnt_res1;  // clears bit 5
	logic       clr_any_d;
	logic       int5_d;

	// ============================================================
	// edge detect
	// ============================================================

	always_ff @(posedge clk) begin
		if (int_reset) begin
			hsync_raw_d <= 1'b0;
			vsync_raw_d <= 1'b0;
			hsync_out_d <= 1'b0;
			vsync_out_d <= 1'b0;
		end else begin
			hsync_raw_d <= hsync_raw;
			vsync_raw_d <= vsync_raw;
			hsync_out_d <= hsync_out;
			vsync_out_d <= vsync_out;
		end
	end

	assign hcnt_cnt     = hsync_raw_d & ~hsync_raw;
	assign vs_raw_rise  = vsync_raw & ~vsync_raw_d;
	assign vs_out_rise  = vsync_out & ~vsync_out_d;
	assign mode_sync_en = hsync_out_d & ~hsync_out;

	// ============================================================
	// hsync delay, 0 1 6 7 4 5 8; bit 2 is the output
	// ============================================================

	always_ff @(posedge clk) begin
		if (int_reset) begin
			hdelay <= 4'h0;
		end else if (!hsync_raw) begin
			hdelay <= 4'h0; // raw low cuts it short
		end else if (cclk_en) begin
			case (hdelay)
				4'h0: hdelay <= 4'h1;
				4'h1: hdelay <= 4'h6; // out rises, 2nd char
				4'h6: hdelay <= 4'h7;
				4'h7: hdelay <= 4'h4;
				4'h4: hdelay <= 4'h5;
				4'h5: hdelay <= 4'h8; // out falls after 4 chars
				default: hdelay <= hdelay; // 8 parks until raw falls
			endcase
		end
	end

	assign hsync_out = hdelay[2];

	// ============================================================
	// vsync line counter
	// ============================================================

	// pairs of 2, skipping 2; out active on 04..07
	always_comb begin
		case (vline_cnt)
			5'h00: vline_next = 5'h01;
			5'h01: vline_next = 5'h06;
			5'h06: vline_next = 5'h07;
			5'h07: vline_next = 5'h04;
			5'h04: vline_next = 5'h05;
			5'h05: vline_next = 5'h0A;
			5'h0A: vline_next = 5'h0B;
			5'h0B: vline_next = 5'h08;
			5'h08: vline_next = 5'h09;
			5'h09: vline_next = 5'h0E;
			5'h0E: vline_next = 5'h0F;
			5'h0F: vline_next = 5'h0C;
			5'h0C: vline_next = 5'h0D;
			5'h0D: vline_next = 5'h12;
			5'h12: vline_next = 5'h13;
			5'h13: vline_next = 5'h10;
			5'h10: vline_next = 5'h11;
			5'h11: vline_next = 5'h16;
			5'h16: vline_next = 5'h17;
			5'h17: vline_next = 5'h14;
			5'h14: vline_next = 5'h15;
			5'h15: vline_next = 5'h1A;
			5'h1A: vline_next = 5'h1B;
			5'h1B: vline_next = 5'h18;
			5'h18: vline_next = 5'h19;
			5'h19: vline_next = VLINE_PARK;
			default: vline_next = vline_cnt; // saturate
		endcase
	end

	always_ff @(posedge clk) begin
		if (int_reset) begin
			vline_cnt <= VLINE_PARK;
		end else if (vs_raw_rise) begin
			vline_cnt <= 5'h00;
		end else if (hcnt_cnt) begin
			vline_cnt <= vline_next;
		end
	end

	assign vsync_out = vline_cnt[2] & ~vline_cnt[3] & ~vline_cnt[4];
	assign csync_n   = ~(hsync_out ^ vsync_out);

	// ============================================================
	// raster interrupt
	// ============================================================

	assign irq_clr_any = irq_clear | irqack;
	assign intcnt_res0 = clr52 | vs_out_rise | irq_clear;
	assign intcnt_res1 = intcnt_res0 | irqack; // ack keeps the low bits

	always_comb begin
		intcnt_nxt = intcnt;
		if (intcnt_res0) begin
			intcnt_nxt[4:0] = 5'd0;
		end else if (hcnt_cnt) begin
			intcnt_nxt = intcnt + 6'd1;
		end
		if (intcnt_res1) begin
			intcnt_nxt[5] = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (int_reset) begin
			intcnt    <= 6'd0;
			int5_d    <= 1'b0;
			clr_any_d <= 1'b0;
			clr52     <= 1'b0;
			irqack    <= 1'b0;
			int_n     <= 1'b1;
		end else begin
			intcnt    <= intcnt_nxt;
			int5_d    <= intcnt[5];
			clr_any_d <= irq_clr_any;
			// counter shows 52 for one clk, then held at 0
			if (hsync_raw) begin
				clr52 <= 1'b0;
			end else if (hcnt_cnt && intcnt_nxt == 6'(video_timing_pkg::INT_LINES)) begin
				clr52 <= 1'b1;
			end
			// ack cycle, m1 and iorq low while int pending
			if (!int_n && !iorq_n && !m1_n) begin
				irqack <= 1'b1;
			end else if (m1_n) begin
				irqack <= 1'b0;
			end
			// bit 5 fall fires, unless a clear caused it
			if (irq_clr_any) begin
				int_n <= 1'b1;
			end else if (int5_d && !intcnt[5] && !clr_any_d) begin
				int_n <= 1'b0;
			end
		end
	end

endmodule

// File: source/video_timing_pkg.sv
// raster defaults give a 312-line 64-char frame; INT_LINES and the vsync shaping are fixed
package video_timing_pkg;

	// ============================================================
	// enums
	// ============================================================

	typedef enum logic [1:0] {
		MODE_0 = 2'd0, // 160 wide, 16 colours
		MODE_1 = 2'd1, // 320 wide, 4 colours, reset mode
		MODE_2 = 2'd2, // 640 wide, 2 colours
		MODE_3 = 2'd3  // 160 wide, 4 colours, undocumented
	} screen_mode_e;

	// where crtc_timing is within the line
	typedef enum logic [1:0] {
		HP_DISPLAY = 2'd0,
		HP_PORCH   = 2'd1, // after sync until line end
		HP_SYNC    = 2'd2
	} hphase_e;

	// ============================================================
	// timing defaults, 32-bit words
	// ============================================================

	localparam int DEF_CLK_DIV     = 4;   // clocks per char clock
	localparam int DEF_H_TOTAL     = 64;  // chars per line
	localparam int DEF_HSYNC_START = 46;
	localparam int DEF_HSYNC_WIDTH = 14;  // raw, in chars
	localparam int DEF_V_TOTAL     = 312; // lines per frame
	localparam int DEF_VSYNC_START = 240;
	localparam int DEF_VSYNC_WIDTH = 8;   // raw, in lines
	localparam int INT_LINES       = 52;  // lines per raster int
	localparam int VSYNC_OUT_DELAY = 2;   // raw vsync to monitor vsync
	localparam int VSYNC_OUT_LINES = 4;

endpackage

// File: source/z80_bus_pkg.sv
// only the gate-array function field and the mode/ROM register bits used by the decoder
package z80_bus_pkg;

	// ============================================================
	// gate-array function, io_data[7:6]
	// ============================================================

	typedef enum logic [1:0] {
		FUNC_PEN_SEL  = 2'b00, // pen / border select
		FUNC_COLOUR   = 2'b01, // colour for selected pen
		FUNC_MODE_ROM = 2'b10, // screen mode, ROM enables, int clear
		FUNC_RAM_CFG  = 2'b11  // RAM banking, handled elsewhere
	} ga_func_e;

	// ============================================================
	// mode/ROM control register bits
	// ============================================================

	// bits 1:0 carry the requested screen mode
	localparam int RMR_MODE_LSB = 0;

	// bits 3:2 are the ROM disables, not modelled here

	// set -> clear raster int counter and pending int
	localparam int RMR_INT_CLR_BIT = 4;

endpackage

// File: verif/gate_array_video_stim.txt
# columns opcode, operand (hex), expected (hex)
# run = lines and int_n falls, write = data and mode, ack = held lines, check_mode = mode
CHECK_MODE 0 1
RUN 100 5
WRITE 80 0
CHECK_MODE 0 0
WRITE 02 0
WRITE C3 0
RUN 28 1
WRITE 92 2
RUN 100 4
ACK 3 0
RUN 80 2
WRITE 91 1
RUN 1A0 8
CHECK_MODE 0 1
WRITE 50 1
WRITE A0 0
CHECK_MODE 0 0
RUN 40 1

// File: verif/tb_gate_array_video.sv
// default raster parameters only; expects the stim rows in order from reset, one run, no restarts
`timescale 1ns/1ns

module tb_gate_array_video;

	localparam int LINE_CLKS = video_timing_pkg::DEF_H_TOTAL * video_timing_pkg::DEF_CLK_DIV;
	localparam int BIT5_LINES = 32; // int counter top bit

	logic clk;
	logic int_reset;
	logic a15;
	logic iorq_n;
	logic wr_n;
	logic m1_n;
	logic [7:0] io_data;
	logic hsync_out;
	logic vsync_out;
	logic csync_n;
	logic int_n;
	video_timing_pkg::screen_mode_e video_mode;

	int cycles;
	int limit_cycles;
	int err_cnt;
	int line_cnt;      // hsync_out falls since reset
	int int_cnt;       // int_n falls since reset
	int cnt_base;      // line of last int counter clear
	int exp_int_line;
	int exp_vs_line;
	int vs_rise_line;
	int hs_rise_cyc;
	logic hs_p;
	logic vs_p;
	logic int_p;
	video_timing_pkg::screen_mode_e mode_now; // mode the DUT should show

	logic [95:0] ops[$];
	int args[$];
	int exps[$];

	gate_array_video dut (
		.clk        (clk),
		.int_reset  (int_reset),
		.a15        (a15),
		.iorq_n     (iorq_n),
		.wr_n       (wr_n),
		.m1_n       (m1_n),
		.io_data    (io_data),
		.hsync_out  (hsync_out),
		.vsync_out  (vsync_out),
		.csync_n    (csync_n),
		.int_n      (int_n),
		.video_mode (video_mode)
	);

	always #2 clk = ~clk; // 4 ns

	// ============================================================
	// compare tasks
	// ============================================================

	task automatic fail_plain(input string why);
		err_cnt++;
		$display("%s", why);
		$display("Test failures found");
		$fatal(1, "run stopped");
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			err_cnt++;
			$display("[ERROR] %s expected 0x%0h actual 0x%0h", name, exp, act);
			$display("Test failures found");
			$fatal(1, "first mismatch");
		end
	endtask

	task automatic check_mode(input string name, input video_timing_pkg::screen_mode_e exp,
			input video_timing_pkg::screen_mode_e act);
		if (act !== exp) begin
			err_cnt++;
			$display("[ERROR] %s expected 0x%0h actual 0x%0h", name, exp, act);
			$display("Test failures found");
			$fatal(1, "first mismatch");
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			err_cnt++;
			$display("[ERROR] %s expected 0x%0h actual 0x%0h", name, exp, act);
			$display("Test failures found");
			$fatal(1, "first mismatch");
		end
	endtask

	// ============================================================
	// timeout and line / interrupt model
	// ============================================================

	always @(posedge clk) begin
		cycles++;
		if (limit_cycles > 0 && cycles > limit_cycles) begin
			fail_plain($sformatf("timeout, run did not finish in %0d clocks", limit_cycles));
		end
	end

	// sampled mid cycle away from the edge
	always @(negedge clk) begin
		if (int_reset) begin
			line_cnt     = 0;
			int_cnt      = 0;
			cnt_base     = 0;
			exp_int_line = video_timing_pkg::INT_LINES;
			exp_vs_line  = video_timing_pkg::DEF_VSYNC_START + video_timing_pkg::VSYNC_OUT_DELAY;
			hs_p         = 1'b0;
			vs_p         = 1'b0;
			int_p        = 1'b1;
		end else begin
			// composite sync low while exactly one sync is active
			check_bit("csync_n", hsync_out == vsync_out, csync_n);
			if (hsync_out && !hs_p) begin
				hs_rise_cyc = cycles;
			end
			if (!hsync_out && hs_p) begin
				check_count("hsync_out width", 4 * video_timing_pkg::DEF_CLK_DIV,
					cycles - hs_rise_cyc); // 4 char clocks
				line_cnt++;
				if (int_n && line_cnt > exp_int_line) begin
					fail_plain($sformatf("interrupt due at line %0d never came", exp_int_line));
				end
			end
			if (vsync_out && !vs_p) begin
				check_count("vsync_out rise line", exp_vs_line, line_cnt);
				exp_vs_line += video_timing_pkg::DEF_V_TOTAL;
				vs_rise_line = line_cnt;
				// top bit set -> its clear fires an int now
				if (line_cnt - cnt_base >= BIT5_LINES) begin
					exp_int_line = line_cnt;
				end else begin
					exp_int_line = line_cnt + video_timing_pkg::INT_LINES;
				end
				cnt_base = line_cnt;
			end
			if (!vsync_out && vs_p) begin
				check_count("vsync_out lines", video_timing_pkg::VSYNC_OUT_LINES,
					line_cnt - vs_rise_line);
			end
			if (!int_n && int_p) begin
				check_count("int_n fall line", exp_int_line, line_cnt);
				int_cnt++;
				cnt_base     = line_cnt;
				exp_int_line = line_cnt + video_timing_pkg::INT_LINES;
			end
			hs_p  = hsync_out;
			vs_p  = vsync_out;
			int_p = int_n;
		end
	end

	// ============================================================
	// bus tasks driven 1 ns after the rising edge
	// ============================================================

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic wait_hs_fall();
		logic prev;
		do begin
			prev = hsync_out;
			step();
		end while (!(prev && !hsync_out));
	endtask

	task automatic ack_int();
		m1_n   = 1'b0; // m1 and iorq together
		iorq_n = 1'b0;
		step();
		step();
		check_bit("int_n", 1'b1, int_n);
		m1_n   = 1'b1;
		iorq_n = 1'b1;
		step();
	endtask

	task automatic run_lines(input int n, input int exp);
		int start_int;
		int target;
		start_int = int_cnt;
		target    = line_cnt + n;
		while (line_cnt < target) begin
			step();
			if (!int_n) begin
				ack_int(); // CPU takes every int
			end
		end
		check_count("int_n falls", exp, int_cnt - start_int);
	endtask

	task automatic hold_ack(input int n);
		int target;
		while (int_n) begin
			step();
		end
		target = line_cnt + n;
		while (line_cnt < target) begin
			step();
		end
		check_bit("int_n", 1'b0, int_n); // still pending
		ack_int();
	endtask

	task automatic io_write(input logic [7:0] data, input video_timing_pkg::screen_mode_e exp_mode);
		logic clr;
		logic prev;
		int gap;
		video_timing_pkg::screen_mode_e old;
		clr = (z80_bus_pkg::ga_func_e'(data[7:6]) == z80_bus_pkg::FUNC_MODE_ROM) &&
		      data[z80_bus_pkg::RMR_INT_CLR_BIT];
		if (clr) begin
			while (int_n) begin
				step(); // leave next int pending
			end
		end
		wait_hs_fall();
		gap = 48 + ($urandom % 64); // past raw hsync fall
		repeat (gap) step();
		old = mode_now;
		if (clr) begin
			check_bit("int_n", 1'b0, int_n);
		end
		a15     = 1'b0;
		io_data = data;
		iorq_n  = 1'b0;
		wr_n    = 1'b0;
		step();
		step();
		if (clr) begin
			check_bit("int_n", 1'b1, int_n);
			cnt_base     = line_cnt;
			exp_int_line = line_cnt + video_timing_pkg::INT_LINES;
		end
		iorq_n = 1'b1;
		wr_n   = 1'b1;
		a15    = 1'b1;
		do begin
			check_mode("video_mode", old, video_mode); // held until hsync end
			prev = hsync_out;
			step();
		end while (!(prev && !hsync_out));
		check_mode("video_mode", old, video_mode);
		step();
		check_mode("video_mode", exp_mode, video_mode);
		mode_now = exp_mode;
	endtask

	// ============================================================
	// main sequence
	// ============================================================

	initial begin
		int fd;
		int rc;
		int a;
		int e;
		int run_total;
		int others;
		int seed_val;
		logic [95:0] op_txt;
		logic [8*80-1:0] line_buf;
		clk          = 1'b0;
		int_reset    = 1'b1;
		a15          = 1'b1;
		iorq_n       = 1'b1;
		wr_n         = 1'b1;
		m1_n         = 1'b1;
		io_data      = 8'h00;
		cycles       = 0;
		limit_cycles = 0;
		err_cnt      = 0;
		run_total    = 0;
		others       = 0;
		mode_now     = video_timing_pkg::MODE_1; // reset mode
		seed_val     = $urandom(19);
		fd = $fopen("verif/gate_array_video_stim.txt", "r");
		if (fd == 0) begin
			fail_plain("could not open the stim file");
		end
		while ($fgets(line_buf, fd) != 0) begin
			rc = $sscanf(line_buf, "%s %h %h", op_txt, a, e);
			if (rc == 3) begin // comment lines fall out here
				ops.push_back(op_txt);
				args.push_back(a);
				exps.push_back(e);
				if (op_txt == "RUN") begin
					run_total += a;
				end else begin
					others++;
				end
			end
		end
		$fclose(fd);
		// writes and acks may wait a whole int period
		limit_cycles = (run_total + 64 * others + 64) * LINE_CLKS;
		repeat (4) @(posedge clk);
		#1;
		int_reset = 1'b0;
		for (int i = 0; i < ops.size(); i++) begin
			if (ops[i] == "RUN") begin
				run_lines(args[i], exps[i]);
			end else if (ops[i] == "WRITE") begin
				io_write(args[i][7:0], video_timing_pkg::screen_mode_e'(exps[i][1:0]));
			end else if (ops[i] == "ACK") begin
				hold_ack(args[i]);
			end else if (ops[i] == "CHECK_MODE") begin
				check_mode("video_mode", video_timing_pkg::screen_mode_e'(exps[i][1:0]),
					video_mode);
			end else begin
				fail_plain($sformatf("unknown opcode in stim row %0d", i));
			end
		end
		if (err_cnt == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule
